// File: src.f
+incdir+include
src/scope_pkg.sv
src/cmd_control.sv
src/arg_collector.sv
src/config_regs.sv
src/readout_engine.sv
src/scope_node.sv
tb/tb_clock.sv
tb/scope_node_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the scope node testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module scope_node_tb \
	-o scope_node_tb_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/scope_node_tb_sim > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }

cat sim.log
grep -q "Something failed" sim.log && { echo "run failed"; exit 1; } || echo "run passed"

// File: tb/scope_node_tb.sv
// directed testbench for the scope node with RAM and transmitter models, run as the simulation top
`timescale 1ns/1ps
`include "scope_params.svh"

module scope_node_tb import scope_pkg::*; ();
	localparam int TRIG_TOP = (1 << `SCOPE_RAM_AW) - `SCOPE_TRIG_MARGIN; // highest trigger point
	localparam logic [7:0] MY_ID = 8'd3;

	logic                     clk, reset;
	logic                     rx_valid = 1'b0;
	logic [7:0]               rx_data = 8'h00;
	logic                     tx_busy = 1'b0; // driven by the transmitter model
	ram_rd_t                  ram_rd = '0; // driven by the RAM model
	logic [`SCOPE_RAM_AW-1:0] wr_ptr = '0;
	logic                     trig_ready = 1'b0;
	logic                     fwd_valid, tx_start, arm, passthrough, is_last;
	logic [7:0]               fwd_data, tx_data;
	logic [`SCOPE_RAM_AW-1:0] ram_addr;
	trig_cfg_t                trig_cfg;

	int         errors = 0;
	int         checks = 0;
	int         tests = 0;
	int         arm_cnt = 0; // arm pulses seen so far
	int         busy_left = 0;
	logic [7:0] tx_q[$]; // every byte the node sent
	logic [7:0] exp_q[$];
	trig_cfg_t  exp_trig; // expected trigger settings
	int         exp_tp, exp_samples, exp_incr; // expected readout settings

	tb_clock tb_clock_i (.clk, .reset);

	scope_node scope_node_i (
		.clk, .reset, .rx_valid, .rx_data, .tx_busy, .ram_rd, .wr_ptr, .trig_ready,
		.fwd_valid, .fwd_data, .tx_start, .tx_data, .ram_addr, .arm, .passthrough,
		.is_last, .trig_cfg
	);

	// sample RAM contents, high nibble folded in so every address bit matters
	function automatic ram_rd_t ram_word(input logic [`SCOPE_RAM_AW-1:0] addr);
		ram_rd_t w;
		for (int c = 0; c < `SCOPE_NCHAN; c++) begin
			w.ch[c] = addr[7:0] ^ {4'h0, addr[11:8]} ^ 8'(c * 'h40);
		end
		return w;
	endfunction

	always @(posedge clk) ram_rd <= ram_word(ram_addr); // registered read

	// transmitter, busy for 5 cycles after each start
	always @(posedge clk) begin
		if (reset) begin
			tx_busy   <= 1'b0;
			busy_left <= 0;
		end else if (tx_start) begin
			tx_busy   <= 1'b1;
			busy_left <= 5;
		end else if (busy_left > 1) begin
			busy_left <= busy_left - 1;
		end else begin
			tx_busy   <= 1'b0;
			busy_left <= 0;
		end
	end

	always @(posedge clk) begin
		if (!reset && tx_start) tx_q.push_back(tx_data); // byte log
		if (!reset && arm) arm_cnt++;
	end

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic report(input string name, input int err_before);
		tests++;
		$display("test %s finished with %0d errors", name, errors - err_before);
	endtask

	task automatic send_byte(input logic [7:0] b);
		@(posedge clk);
		rx_valid <= 1'b1;
		rx_data  <= b;
		@(posedge clk);
		rx_valid <= 1'b0;
	endtask

	// byte goes in, chain output one cycle later
	task automatic send_fwd(input logic [7:0] b, input logic [7:0] exp);
		send_byte(b);
		@(posedge clk);
		check_value("fwd_valid", fwd_valid, 1'b1);
		check_value("fwd_data", fwd_data, exp);
	endtask

	task automatic send_arg1(input logic [7:0] op, input logic [7:0] a);
		send_fwd(op, op);
		send_fwd(a, a); // argument bytes travel on unchanged
	endtask

	task automatic send_arg2(input logic [7:0] op, input logic [15:0] v);
		send_fwd(op, op);
		send_fwd(v[15:8], v[15:8]); // high byte first
		send_fwd(v[7:0], v[7:0]);
	endtask

	task automatic set_trig_point(input logic [15:0] v);
		send_arg2(OP_TRIG_POINT, v);
		if (v > TRIG_TOP) exp_tp = TRIG_TOP;
		else if (v < `SCOPE_TRIG_MIN) exp_tp = `SCOPE_TRIG_MIN;
		else exp_tp = v;
	endtask

	task automatic set_samples(input logic [15:0] v);
		send_arg2(OP_SAMPLES, v);
		exp_samples = v[11:0];
		if (exp_samples != 0 && exp_tp + 5 > exp_samples) exp_tp = exp_samples / 2; // pulled in
	endtask

	task automatic set_incr(input logic [3:0] v);
		send_arg1(OP_SEND_INCR, {4'($urandom), v}); // high nibble is ignored
		exp_incr = v;
	endtask

	// select this board, fire the trigger and compare the byte stream
	task automatic run_readout(input logic [11:0] wp);
		int         base, n, waited, limit, c, k;
		ram_rd_t    w;
		exp_q.delete();
		limit = (exp_samples == 0) ? (1 << `SCOPE_RAM_AW) : exp_samples;
		for (c = 0; c < `SCOPE_NCHAN; c++) begin
			for (k = 0; k < limit; k += (1 << exp_incr)) begin
				w = ram_word(12'(wp - exp_tp + k)); // pre-trigger window, wraps
				exp_q.push_back(w.ch[c]);
			end
		end
		n = exp_q.size();
		@(posedge clk);
		wr_ptr <= wp;
		base = tx_q.size();
		send_byte(MY_ID + 8'd10);
		@(posedge clk);
		check_value("fwd_valid", fwd_valid, 1'b0); // selector is not forwarded
		trig_ready <= 1'b1;
		waited = 0;
		while (tx_q.size() < base + n && waited < n * 12 + 200) begin
			@(posedge clk);
			waited++;
		end
		if (tx_q.size() < base + n) begin
			errors++;
			$display("timeout, readout sent %0d of %0d bytes", tx_q.size() - base, n);
		end
		repeat (10) @(posedge clk); // trailing bytes would show up here
		trig_ready <= 1'b0;
		check_value("tx byte count", tx_q.size() - base, n);
		for (k = 0; k < n && base + k < tx_q.size(); k++) begin
			check_value($sformatf("tx_data[%0d]", k), tx_q[base + k], exp_q[k]);
		end
		check_value("passthrough", passthrough, 1'b0);
	endtask

	task automatic test_id_chain();
		int e0;
		e0 = errors;
		check_value("trig_cfg", trig_cfg, exp_trig); // reset values
		check_value("is_last", is_last, 1'b0);
		send_fwd(8'd3, 8'd4); // id plus one goes down the chain
		send_fwd(8'd23, 8'd23);
		check_value("is_last", is_last, 1'b1);
		send_fwd(8'd25, 8'd25);
		check_value("is_last", is_last, 1'b0);
		report("id_chain", e0);
	endtask

	task automatic test_trig_settings();
		int         e0;
		logic [7:0] r;
		logic [1:0] c;
		e0 = errors;
		r = 8'($urandom);
		send_arg1(OP_THRESH, r);
		exp_trig.thresh = r;
		check_value("trig_cfg", trig_cfg, exp_trig);
		r = 8'($urandom);
		send_arg1(OP_THRESH_HI, r);
		exp_trig.thresh_hi = r;
		check_value("trig_cfg", trig_cfg, exp_trig);
		r = 8'($urandom);
		send_arg1(OP_TRIG_TYPE, r);
		exp_trig.trig_type = r[3:0]; // low nibble only
		check_value("trig_cfg", trig_cfg, exp_trig);
		c = 2'($urandom);
		send_arg1(OP_CHAN_TOGGLE, {MY_ID[5:0], c});
		exp_trig.channels[c] = ~exp_trig.channels[c];
		check_value("trig_cfg", trig_cfg, exp_trig);
		send_arg1(OP_CHAN_TOGGLE, {6'd5, c}); // other board, no change
		check_value("trig_cfg", trig_cfg, exp_trig);
		send_fwd(OP_ROLL_OFF, OP_ROLL_OFF);
		exp_trig.rolling = 1'b0;
		check_value("trig_cfg", trig_cfg, exp_trig);
		send_fwd(OP_ROLL_ON, OP_ROLL_ON);
		exp_trig.rolling = 1'b1;
		check_value("trig_cfg", trig_cfg, exp_trig);
		report("trig_settings", e0);
	endtask

	task automatic test_arm();
		int e0, a0;
		e0 = errors;
		a0 = arm_cnt;
		send_fwd(OP_ARM, OP_ARM);
		check_value("arm", arm, 1'b1);
		@(posedge clk);
		check_value("arm", arm, 1'b0); // single cycle pulse
		check_value("arm pulses", arm_cnt - a0, 1);
		report("arm", e0);
	endtask

	task automatic test_readout();
		int e0, base;
		e0 = errors;
		set_incr(4'd1);
		set_samples(16'd40); // trigger point 1024 drops to 20
		run_readout(12'($urandom));
		set_incr(4'd8);
		set_samples(16'd0); // whole RAM
		set_trig_point(16'd9000); // clamped to the top
		run_readout(12'($urandom));
		set_incr(4'd2);
		set_samples(16'(64 + $urandom % 64));
		set_trig_point(16'($urandom % 8)); // often below the minimum
		run_readout(12'($urandom));
		base = tx_q.size();
		send_fwd(MY_ID + 8'd12, MY_ID + 8'd12); // another board is read
		check_value("passthrough", passthrough, 1'b1);
		trig_ready <= 1'b1;
		repeat (50) @(posedge clk);
		trig_ready <= 1'b0;
		check_value("tx byte count", tx_q.size() - base, 0);
		report("readout", e0);
	endtask

	task automatic test_timeout();
		int e0, base;
		e0 = errors;
		base = tx_q.size();
		send_byte(MY_ID + 8'd10); // trig_ready stays low
		repeat (`SCOPE_WAIT_TIMEOUT + 20) @(posedge clk);
		check_value("tx byte count", tx_q.size() - base, 0);
		check_value("passthrough", passthrough, 1'b0); // was set by the other board's select
		send_fwd(MY_ID, MY_ID + 8'd1); // commands taken again
		report("timeout", e0);
	endtask

	task automatic test_autorearm();
		int e0, a0;
		e0 = errors;
		send_fwd(OP_AUTOREARM, OP_AUTOREARM);
		set_samples(16'd12);
		a0 = arm_cnt;
		run_readout(12'($urandom));
		check_value("arm pulses", arm_cnt - a0, 1); // rearm after the last byte
		send_fwd(OP_AUTOREARM, OP_AUTOREARM);
		report("autorearm", e0);
	endtask

	initial begin
		int n;
		void'($urandom(5));
		exp_trig = '{rolling: 1'b1, thresh: 8'h80, thresh_hi: 8'hff, trig_type: 4'd1,
			channels: 4'hf};
		exp_tp      = 1024;
		exp_samples = 0;
		exp_incr    = 0;
		@(posedge clk);
		n = 0;
		while (reset && n < 20) begin
			@(posedge clk);
			n++;
		end
		if (reset) begin
			errors++;
			$display("reset was never released");
		end
		test_id_chain();
		test_trig_settings();
		test_arm();
		test_readout();
		test_timeout();
		test_autorearm();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: tb/tb_clock.sv
// clock and reset source for the scope node testbench, instantiate once in the testbench top
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic reset
);
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	initial begin
		reset = 1'b1; // held over the first three rising edges
		repeat (3) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

// File: src/scope_node.sv
// top of the scope command node, connects the controller and datapath to UART, chain, RAM and trigger
`timescale 1ns/1ps
`include "scope_params.svh"

module scope_node import scope_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     rx_valid, // one cycle per host byte
	input  logic [7:0]               rx_data,
	input  logic                     tx_busy,
	input  ram_rd_t                  ram_rd, // valid one cycle after ram_addr
	input  logic [`SCOPE_RAM_AW-1:0] wr_ptr, // write pointer at the trigger
	input  logic                     trig_ready, // level, capture done
	output logic                     fwd_valid, // to the next board
	output logic [7:0]               fwd_data,
	output logic                     tx_start,
	output logic [7:0]               tx_data,
	output logic [`SCOPE_RAM_AW-1:0] ram_addr,
	output logic                     arm,
	output logic                     passthrough,
	output logic                     is_last,
	output trig_cfg_t                trig_cfg
);
	logic       byte_valid, collect_ok, collecting; // controller to collector
	logic [7:0] byte_data;
	logic       arg_done, op_valid, autorearm;
	scope_op_e  arg_op, op_code;
	arg_word_u  arg_word;
	logic [7:0] my_id;
	logic       ro_start, ro_done; // readout handshake
	ro_cfg_t    ro_cfg;

	cmd_control cmd_control_i (
		.clk, .reset, .rx_valid, .rx_data, .collecting, .arg_done, .arg_op,
		.autorearm, .trig_ready, .ro_done, .fwd_valid, .fwd_data, .byte_valid,
		.byte_data, .collect_ok, .op_valid, .op_code, .my_id, .passthrough,
		.is_last, .arm, .ro_start
	);

	arg_collector arg_collector_i (
		.clk, .reset, .byte_valid, .byte_data, .collect_ok,
		.collecting, .arg_done, .arg_op, .arg_word
	);

	config_regs config_regs_i (
		.clk, .reset, .arg_done, .arg_op, .arg_word, .op_valid, .op_code,
		.my_id, .trig_cfg, .ro_cfg, .autorearm
	);

	readout_engine readout_engine_i (
		.clk, .reset, .ro_start, .ro_cfg, .wr_ptr, .ram_rd, .tx_busy,
		.ram_addr, .tx_start, .tx_data, .ro_done
	);

endmodule

// File: src/readout_engine.sv
// walks the sample RAM for all channels and streams the bytes to the UART transmitter
`timescale 1ns/1ps
`include "scope_params.svh"

module readout_engine import scope_pkg::*; (
	input  logic          clk,
	input  logic          reset,
	input  logic          ro_start, // one cycle, trigger seen
	input  ro_cfg_t       ro_cfg,
	input  logic [`SCOPE_RAM_AW-1:0] wr_ptr,
	input  ram_rd_t       ram_rd,
	input  logic          tx_busy,
	output logic [`SCOPE_RAM_AW-1:0] ram_addr,
	output logic          tx_start,
	output logic [7:0]    tx_data,
	output logic          ro_done // with the last tx_start
);
	localparam int AW = `SCOPE_RAM_AW;
	localparam int CW = $clog2(`SCOPE_NCHAN);
	localparam int KW = AW + 5; // offset plus the largest stride

	logic          gen_active; // addresses left to issue
	logic [CW-1:0] gen_chan;
	logic [KW-1:0] k, next_k, step, limit;
	logic [AW-1:0] base; // first sample of every channel
	logic          chan_end, gen_last, issue, pop;

	logic          s1_valid, s1_last; // address on the RAM bus
	logic [CW-1:0] s1_chan;
	logic          s2_valid, s2_last; // data on ram_rd
	logic [CW-1:0] s2_chan;

	logic [7:0]    buf_data [2]; // bytes waiting for the transmitter
	logic [1:0]    buf_last;
	logic          buf_wr, buf_rd;
	logic [1:0]    buf_cnt;

	assign limit    = (ro_cfg.samples == '0) ? KW'(`SCOPE_RAM_DEPTH) : KW'(ro_cfg.samples);
	assign step     = KW'(1) << ro_cfg.incr;
	assign next_k   = k + step;
	assign chan_end = (next_k >= limit);
	assign gen_last = chan_end && (gen_chan == CW'(`SCOPE_NCHAN - 1));
	// at most two entries between address and buffer, so the buffer never overflows
	assign issue    = gen_active && (3'(s1_valid) + 3'(s2_valid) + 3'(buf_cnt) < 3'd2);
	assign pop      = (buf_cnt != 2'd0) && !tx_busy && !tx_start; // busy rises a cycle late

	always_ff @(posedge clk) begin
		if (reset) begin
			gen_active <= 1'b0;
			gen_chan   <= '0;
			k          <= '0;
		end else if (ro_start) begin
			gen_active <= 1'b1;
			gen_chan   <= '0;
			k          <= '0;
		end else if (issue) begin
			if (chan_end) begin
				k        <= '0; // next channel restarts at the base
				gen_chan <= gen_chan + 1'b1;
				if (gen_last) gen_active <= 1'b0;
			end else begin
				k <= next_k;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ro_start) base <= wr_ptr - ro_cfg.trig_point; // wraps in the RAM
		if (issue) begin
			ram_addr <= base + k[AW-1:0];
			s1_chan  <= gen_chan;
			s1_last  <= gen_last;
		end
		s2_chan <= s1_chan;
		s2_last <= s1_last;
		if (s2_valid) begin
			buf_data[buf_wr] <= ram_rd.ch[s2_chan];
			buf_last[buf_wr] <= s2_last;
		end
		if (pop) tx_data <= buf_data[buf_rd];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			buf_wr   <= 1'b0;
			buf_rd   <= 1'b0;
			buf_cnt  <= '0;
			tx_start <= 1'b0;
			ro_done  <= 1'b0;
		end else begin
			s1_valid <= issue;
			s2_valid <= s1_valid; // registered RAM read
			if (s2_valid) buf_wr <= ~buf_wr;
			if (pop) buf_rd <= ~buf_rd;
			buf_cnt  <= buf_cnt + 2'(s2_valid) - 2'(pop);
			tx_start <= pop;
			ro_done  <= pop && buf_last[buf_rd];
		end
	end

	// transmitter handshake, busy follows start by one cycle
	a_no_start_busy: assert property (@(posedge clk) disable iff (reset)
		tx_start |-> !tx_busy);

endmodule

// File: src/config_regs.sv
// trigger and readout settings of the scope node, updated by argument commands and single byte ops
`timescale 1ns/1ps
`include "scope_params.svh"

module config_regs import scope_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       arg_done,
	input  scope_op_e  arg_op,
	input  arg_word_u  arg_word,
	input  logic       op_valid,
	input  scope_op_e  op_code,
	input  logic [7:0] my_id,
	output trig_cfg_t  trig_cfg,
	output ro_cfg_t    ro_cfg,
	output logic       autorearm
);
	localparam int AW = `SCOPE_RAM_AW;
	localparam logic [15:0] TRIG_LO = 16'(`SCOPE_TRIG_MIN);
	localparam logic [15:0] TRIG_HI = 16'(`SCOPE_RAM_DEPTH - `SCOPE_TRIG_MARGIN);

	logic [AW-1:0] samp_new; // sample count carried by op 122
	logic          board_hit; // channel toggle addressed to us

	assign samp_new  = arg_word.count[AW-1:0];
	assign board_hit = ({2'b00, arg_word.chan_sel.board} == my_id);

	always_ff @(posedge clk) begin
		if (reset) begin
			trig_cfg.rolling   <= 1'b1;
			trig_cfg.thresh    <= 8'h80;
			trig_cfg.thresh_hi <= 8'hff;
			trig_cfg.trig_type <= 4'd1; // rising edge
			trig_cfg.channels  <= '1;
			ro_cfg.trig_point  <= AW'(1024);
			ro_cfg.samples     <= '0; // whole RAM
			ro_cfg.incr        <= '0;
			autorearm          <= 1'b0;
		end else if (arg_done) begin
			case (arg_op)
				OP_TRIG_POINT: begin
					if (arg_word.count > TRIG_HI) ro_cfg.trig_point <= TRIG_HI[AW-1:0];
					else if (arg_word.count < TRIG_LO) ro_cfg.trig_point <= TRIG_LO[AW-1:0];
					else ro_cfg.trig_point <= arg_word.count[AW-1:0];
				end
				OP_SAMPLES: begin
					ro_cfg.samples <= samp_new;
					// keep the trigger inside a short window
					if (samp_new >= AW'(5) && ro_cfg.trig_point > samp_new - AW'(5)) begin
						ro_cfg.trig_point <= samp_new >> 1;
					end
				end
				OP_SEND_INCR: ro_cfg.incr <= arg_word.count[11:8];
				OP_THRESH: trig_cfg.thresh <= arg_word.count[15:8];
				OP_THRESH_HI: trig_cfg.thresh_hi <= arg_word.count[15:8];
				OP_TRIG_TYPE: trig_cfg.trig_type <= arg_word.count[11:8];
				OP_CHAN_TOGGLE: begin
					if (board_hit) begin
						trig_cfg.channels[arg_word.chan_sel.chan] <=
							~trig_cfg.channels[arg_word.chan_sel.chan];
					end
				end
				default: ;
			endcase
		end else if (op_valid) begin
			case (op_code)
				OP_ROLL_ON: trig_cfg.rolling <= 1'b1;
				OP_ROLL_OFF: trig_cfg.rolling <= 1'b0;
				OP_AUTOREARM: autorearm <= ~autorearm;
				default: ;
			endcase
		end
	end

endmodule

// File: src/arg_collector.sv
// gathers the argument bytes after an opcode and presents the completed argument word
`timescale 1ns/1ps

module arg_collector import scope_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       byte_valid,
	input  logic [7:0] byte_data,
	input  logic       collect_ok, // byte is an opcode position
	output logic       collecting,
	output logic       arg_done, // one cycle, with the last argument byte
	output scope_op_e  arg_op,
	output arg_word_u  arg_word
);
	logic [1:0] need; // argument bytes for the current op
	logic [1:0] cnt; // argument bytes taken so far
	logic [1:0] len; // lookup for the incoming byte
	logic [7:0] hi_byte; // first byte of a two byte argument

	// number of argument bytes that follow each opcode
	function automatic logic [1:0] arg_len(input logic [7:0] op);
		case (op)
			OP_TRIG_POINT, OP_SAMPLES: arg_len = 2'd2;
			OP_SEND_INCR, OP_THRESH, OP_TRIG_TYPE,
			OP_CHAN_TOGGLE, OP_THRESH_HI: arg_len = 2'd1;
			default: arg_len = 2'd0;
		endcase
	endfunction

	assign len      = arg_len(byte_data);
	assign arg_done = byte_valid && collecting && (cnt + 2'd1 == need);

	// one byte args land in the high half
	always_comb begin
		arg_word.count = (need == 2'd2) ? {hi_byte, byte_data} : {byte_data, 8'h00};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			collecting <= 1'b0;
			need       <= '0;
			cnt        <= '0;
		end else if (byte_valid) begin
			if (collecting) begin
				cnt <= cnt + 2'd1;
				if (arg_done) collecting <= 1'b0;
			end else if (collect_ok && len != 2'd0) begin
				collecting <= 1'b1; // opcode with arguments
				need       <= len;
				cnt        <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (byte_valid && !collecting && collect_ok) arg_op <= scope_op_e'(byte_data);
		if (byte_valid && collecting) hi_byte <= byte_data; // shift, first byte ends high
	end

	a_cnt_bound: assert property (@(posedge clk) disable iff (reset)
		collecting |-> (cnt < need) && (need <= 2'd2));

endmodule

// File: src/cmd_control.sv
// command FSM of the scope node, handles ID, forwarding, readout select, arm and the trigger wait
`timescale 1ns/1ps
`include "scope_params.svh"

module cmd_control import scope_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       rx_valid,
	input  logic [7:0] rx_data,
	input  logic       collecting, // collector expects argument bytes
	input  logic       arg_done,
	input  scope_op_e  arg_op,
	input  logic       autorearm,
	input  logic       trig_ready,
	input  logic       ro_done, // last byte handed to the transmitter
	output logic       fwd_valid,
	output logic [7:0] fwd_data,
	output logic       byte_valid, // every byte taken while idle
	output logic [7:0] byte_data,
	output logic       collect_ok, // byte may open an argument
	output logic       op_valid, // single byte config op
	output scope_op_e  op_code,
	output logic [7:0] my_id,
	output logic       passthrough,
	output logic       is_last,
	output logic       arm,
	output logic       ro_start
);
	localparam int TW = $clog2(`SCOPE_WAIT_TIMEOUT + 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT, // selected for readout, trigger not seen yet
		ST_READOUT
	} state_e;

	state_e        state;
	logic [TW-1:0] wait_cnt; // cycles spent in ST_WAIT
	logic          is_cmd; // byte is an opcode, not an argument

	assign is_cmd     = !collecting;
	assign byte_valid = rx_valid && (state == ST_IDLE); // bytes during readout are dropped
	assign byte_data  = rx_data;
	assign collect_ok = is_cmd && (rx_data >= 8'(`SCOPE_LAST_LIMIT)); // chain codes never take args
	assign op_code    = scope_op_e'(rx_data);
	assign op_valid   = byte_valid && is_cmd &&
		(op_code inside {OP_ROLL_ON, OP_ROLL_OFF, OP_AUTOREARM});

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= ST_IDLE;
			wait_cnt    <= '0;
			fwd_valid   <= 1'b0;
			my_id       <= 8'hff; // unassigned
			passthrough <= 1'b0;
			is_last     <= 1'b0;
			arm         <= 1'b0;
			ro_start    <= 1'b0;
		end else begin
			fwd_valid <= 1'b0; // pulses
			arm       <= 1'b0;
			ro_start  <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (byte_valid) begin
						if (!is_cmd) begin
							fwd_valid <= 1'b1; // argument byte, pass along
						end else if (rx_data < 8'(`SCOPE_ID_LIMIT)) begin
							my_id     <= rx_data;
							fwd_valid <= 1'b1; // next board gets the next id
						end else if (rx_data < 8'(`SCOPE_SEL_LIMIT)) begin
							if (rx_data == my_id + 8'(`SCOPE_ID_LIMIT)) begin
								passthrough <= 1'b0; // we talk to the host ourselves
								wait_cnt    <= '0;
								state       <= ST_WAIT;
							end else begin
								passthrough <= 1'b1; // another board answers
								fwd_valid   <= 1'b1;
							end
						end else if (rx_data < 8'(`SCOPE_LAST_LIMIT)) begin
							is_last   <= (rx_data == my_id + 8'(`SCOPE_SEL_LIMIT));
							fwd_valid <= 1'b1;
						end else begin
							arm       <= (op_code == OP_ARM);
							fwd_valid <= 1'b1;
						end
					end
				end
				ST_WAIT: begin
					if (trig_ready) begin
						ro_start <= 1'b1;
						state    <= ST_READOUT;
					end else if (wait_cnt == TW'(`SCOPE_WAIT_TIMEOUT - 1)) begin
						state <= ST_IDLE; // no trigger, send nothing
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				ST_READOUT: begin
					if (ro_done) begin
						arm   <= autorearm; // rearm right after the last byte
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// id byte goes out incremented, everything else unchanged
	always_ff @(posedge clk) begin
		if (byte_valid) begin
			fwd_data <= (is_cmd && rx_data < 8'(`SCOPE_ID_LIMIT)) ? rx_data + 8'd1 : rx_data;
		end
	end

	// readout only starts from a trigger seen while waiting
	a_ro_start_from_wait: assert property (@(posedge clk) disable iff (reset)
		ro_start |-> $past(state) == ST_WAIT);

	// collector must only finish ops that actually carry arguments
	a_arg_done_op: assert property (@(posedge clk) disable iff (reset)
		arg_done |-> byte_valid && !(arg_op inside {OP_ARM, OP_ROLL_ON, OP_ROLL_OFF, OP_AUTOREARM}));

endmodule

// File: src/scope_pkg.sv
// shared opcode, argument and configuration types of the scope node; import in every RTL module
`include "scope_params.svh"

package scope_pkg;

	// opcodes kept from the host protocol
	typedef enum logic [7:0] {
		OP_ARM         = 8'd100, // prime the trigger on every board
		OP_ROLL_ON     = 8'd101,
		OP_ROLL_OFF    = 8'd102,
		OP_TRIG_POINT  = 8'd121, // two argument bytes
		OP_SAMPLES     = 8'd122, // two argument bytes
		OP_SEND_INCR   = 8'd123, // log2 of the read stride
		OP_THRESH      = 8'd127,
		OP_TRIG_TYPE   = 8'd128,
		OP_CHAN_TOGGLE = 8'd130, // board and channel packed in one byte
		OP_AUTOREARM   = 8'd139,
		OP_THRESH_HI   = 8'd140
	} scope_op_e;

	// channel select view of the argument, first byte only
	typedef struct packed {
		logic [5:0] board; // board id the channel belongs to
		logic [1:0] chan; // channel on that board
		logic [7:0] unused; // second byte never sent for this op
	} chan_sel_t;

	// argument word, first byte in the high half
	typedef union packed {
		logic [15:0] count; // plain value view
		chan_sel_t   chan_sel;
	} arg_word_u;

	typedef struct packed {
		logic                     rolling; // free running capture
		logic [7:0]               thresh;
		logic [7:0]               thresh_hi; // signal must stay below this
		logic [3:0]               trig_type; // bit 0 rising edge
		logic [`SCOPE_NCHAN-1:0]  channels; // trigger enable per channel
	} trig_cfg_t;

	typedef struct packed {
		logic [`SCOPE_RAM_AW-1:0] trig_point; // samples sent before the trigger
		logic [`SCOPE_RAM_AW-1:0] samples; // 0 means the whole RAM
		logic [3:0]               incr; // stride is 2**incr
	} ro_cfg_t;

	// one RAM word, byte ch[i] belongs to channel i
	typedef struct packed {
		logic [`SCOPE_NCHAN-1:0][7:0] ch;
	} ram_rd_t;

endpackage

// File: include/scope_params.svh
// sizing, clamp and timeout constants for the scope command node; include in any file that needs them
`ifndef SCOPE_PARAMS_SVH
`define SCOPE_PARAMS_SVH

// sample RAM geometry
`define SCOPE_RAM_AW 12 // address bits of the sample RAM
`define SCOPE_RAM_DEPTH (1 << `SCOPE_RAM_AW) // samples per channel

// channels read out per board
`define SCOPE_NCHAN 4 // channel bytes in one RAM word

// trigger point clamp
// the point must leave some room on both ends of the RAM
`define SCOPE_TRIG_MIN 4 // lowest accepted trigger point
`define SCOPE_TRIG_MARGIN 16 // distance below the RAM depth for the top

// readout wait
// cycles spent waiting for trig_ready before the node gives up and
// goes back to taking commands
`define SCOPE_WAIT_TIMEOUT 2000

// chain decode ranges
// bytes below these limits are ID, readout select and last-board codes
`define SCOPE_ID_LIMIT 10
`define SCOPE_SEL_LIMIT 20
`define SCOPE_LAST_LIMIT 30

`endif
